// ==== Bender.yml ====
package:
  name: pdp8_axi

sources:
  - hw/pdp8Pkg.sv
  - hw/hostPkg.sv
  - hw/memBusIf.sv
  - hw/sequencer.sv
  - hw/accumulatorUnit.sv
  - hw/coreMemory.sv
  - hw/axiLiteHost.sv
  - hw/pdp8Top.sv
  - target: test
    files:
      - tb/pdp8Tb.sv

// ==== hw/accumulatorUnit.sv ====
/*
  AC and Link with AND, TAD and the OPR microcode. Group 3 words leave
  AC and Link untouched. Skip is only meaningful for group 2 words.
*/
module accumulatorUnit (
  input  logic CLK,
  input  logic arstN,
  input  pdp8Pkg::accCmd cmd,
  input  pdp8Pkg::pdp8Word ir,
  input  pdp8Pkg::pdp8Word operand,
  output pdp8Pkg::pdp8Word ac,
  output logic link,
  output logic skip
);
  import pdp8Pkg::*;

  logic [12:0] step1, step2, step3, rotated;
  logic isGroup2;
  logic testHit;

  // Group 1 chain on {link, ac}
  always_comb begin
    step1 = {ir[oprCll] ? 1'b0 : link, ir[oprCla] ? 12'o0000 : ac};
    step2 = step1 ^ {ir[oprCml], {12{ir[oprCma]}}};
    // A carry out of AC flips Link through the 13-bit add
    step3 = step2 + 13'(ir[oprIac]);
    rotated = step3;
    if (ir[oprRal]) begin
      rotated = {step3[11:0], step3[12]};
      if (ir[oprTwice]) rotated = {rotated[11:0], rotated[12]};
    end else if (ir[oprRar]) begin
      rotated = {step3[0], step3[12:1]};
      if (ir[oprTwice]) rotated = {rotated[0], rotated[12:1]};
    end
  end

  // Group 2 tests on the old AC and Link
  assign isGroup2 = (pdp8Opcode'(ir[11:9]) == opOpr) && ir[oprGroupBit]
                    && !ir[oprGroup3Bit];
  assign testHit  = (ir[oprSma] && ac[11]) || (ir[oprSza] && ac == '0)
                    || (ir[oprSnl] && link);
  assign skip     = isGroup2 && (testHit ^ ir[oprRevSense]);

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (cmd)
        accAnd:   ac <= ac & operand;
        accTad:   {link, ac} <= {link, ac} + {1'b0, operand};
        accClear: ac <= '0;
        accOpr: begin
          if (!ir[oprGroupBit])
            {link, ac} <= rotated;
          else if (!ir[oprGroup3Bit] && ir[oprCla])
            ac <= '0;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/axiLiteHost.sv ====
/*
  AXI4-Lite slave for run control and the memory window. One transaction
  at a time, writes win over reads. Control writes need wstrb[0], PC and
  memory writes need both low byte strobes or they are dropped silently.
*/
module axiLiteHost #(
  parameter int memAddrBits = 12
) (
  input  logic CLK,
  input  logic arstN,
  input  logic awvalid,
  output logic awready,
  input  hostPkg::hostAddr awaddr,
  input  logic wvalid,
  output logic wready,
  input  hostPkg::hostData wdata,
  input  logic [3:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output hostPkg::axiResp bresp,
  input  logic arvalid,
  output logic arready,
  input  hostPkg::hostAddr araddr,
  output logic rvalid,
  input  logic rready,
  output hostPkg::hostData rdata,
  output hostPkg::axiResp rresp,
  memBusIf.requester mem,
  input  logic running,
  input  pdp8Pkg::pdp8Word pc,
  input  pdp8Pkg::pdp8Word ac,
  input  logic link,
  output logic startPulse,
  output logic stopPulse,
  output logic startPcLoad,
  output pdp8Pkg::pdp8Word startPc
);
  import hostPkg::*;

  localparam int winShift = memAddrBits + 2;

  typedef enum logic [2:0] {
    hIdle, hWrite, hWriteResp, hRead, hReadMem, hReadResp
  } hostState;

  hostState state;
  logic wrInWindow, rdInWindow;
  logic wordStrobe;

  assign wrInWindow = (awaddr >> winShift) == (memWindow >> winShift);
  assign rdInWindow = (araddr >> winShift) == (memWindow >> winShift);
  assign wordStrobe = &wstrb[1:0];

  assign awready = (state == hWrite);
  assign wready  = (state == hWrite);
  assign bvalid  = (state == hWriteResp);
  assign arready = (state == hRead);
  assign rvalid  = (state == hReadResp);

  // Window accesses go out during the address handshake
  always_comb begin
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = araddr[winShift-1:2];
    mem.wdata = wdata[11:0];
    if (state == hWrite) begin
      mem.addr = awaddr[winShift-1:2];
      mem.req  = wrInWindow && !running && wordStrobe;
      mem.we   = 1'b1;
    end else if (state == hRead) begin
      mem.req = rdInWindow && !running;
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state       <= hIdle;
      bresp       <= respOkay;
      rresp       <= respOkay;
      rdata       <= '0;
      startPulse  <= 1'b0;
      stopPulse   <= 1'b0;
      startPcLoad <= 1'b0;
      startPc     <= '0;
    end else begin
      startPulse  <= 1'b0;
      stopPulse   <= 1'b0;
      startPcLoad <= 1'b0;
      case (state)
        hIdle: begin
          if (awvalid && wvalid) state <= hWrite;
          else if (arvalid) state <= hRead;
        end
        hWrite: begin
          state <= hWriteResp;
          bresp <= respOkay;
          if (awaddr == regCtrl) begin
            startPulse <= wstrb[0] && wdata[ctrlStartBit];
            stopPulse  <= wstrb[0] && wdata[ctrlStopBit];
          end else if (awaddr == regStartPc) begin
            if (running) begin
              bresp <= respSlvErr;
            end else if (wordStrobe) begin
              startPc     <= wdata[11:0];
              startPcLoad <= 1'b1;
            end
          end else if (!wrInWindow || running) begin
            bresp <= respSlvErr;
          end
        end
        hWriteResp: if (bready) state <= hIdle;
        hRead: begin
          state <= hReadResp;
          rresp <= respOkay;
          rdata <= '0;
          if (rdInWindow) begin
            if (running) rresp <= respSlvErr;
            else state <= hReadMem;
          end else begin
            case (araddr)
              regStartPc: rdata <= hostData'(startPc);
              regStatus:  rdata <= hostData'(running) << statusRunBit;
              regPc:      rdata <= hostData'(pc);
              regAc:      rdata <= (hostData'(link) << acLinkBit) | hostData'(ac);
              default:    rresp <= respSlvErr;
            endcase
          end
        end
        hReadMem: begin
          rdata <= hostData'(mem.rdata);
          state <= hReadResp;
        end
        hReadResp: if (rready) state <= hIdle;
        default: state <= hIdle;
      endcase
    end
  end

endmodule

// ==== hw/coreMemory.sv ====
/*
  Core memory of 2**memAddrBits words with two independent ports.
  A write also returns the new word on the same port next cycle.
  Both ports writing one address in one cycle leaves the host word.
*/
module coreMemory #(
  parameter int memAddrBits = 12
) (
  input logic CLK,
  memBusIf.memory cpuPort,
  memBusIf.memory hostPort
);
  import pdp8Pkg::*;

  pdp8Word words [2**memAddrBits];

  always_ff @(posedge CLK) begin
    if (cpuPort.req) begin
      if (cpuPort.we) begin
        words[cpuPort.addr] <= cpuPort.wdata;
        cpuPort.rdata       <= cpuPort.wdata;
      end else begin
        cpuPort.rdata <= words[cpuPort.addr];
      end
    end
    if (hostPort.req) begin
      if (hostPort.we) begin
        words[hostPort.addr] <= hostPort.wdata;
        hostPort.rdata       <= hostPort.wdata;
      end else begin
        hostPort.rdata <= words[hostPort.addr];
      end
    end
  end

endmodule

// ==== hw/hostPkg.sv ====
/*
  Host register map and AXI4-Lite codes. Registers sit at word aligned
  offsets, the memory window holds one 12-bit word per 4 bytes.
*/
package hostPkg;

  typedef logic [15:0] hostAddr;
  typedef logic [31:0] hostData;

  localparam hostAddr regCtrl    = 16'h0000;
  localparam hostAddr regStartPc = 16'h0004;
  localparam hostAddr regStatus  = 16'h0008;
  localparam hostAddr regPc      = 16'h000C;
  localparam hostAddr regAc      = 16'h0010;
  localparam hostAddr memWindow  = 16'h4000;

  localparam int ctrlStartBit = 0;
  localparam int ctrlStopBit  = 1;
  localparam int statusRunBit = 0;
  localparam int acLinkBit    = 12;

  typedef enum logic [1:0] {
    respOkay   = 2'b00,
    respSlvErr = 2'b10
  } axiResp;

endpackage

// ==== hw/memBusIf.sv ====
/*
  One synchronous memory port. Requests last a single cycle and read
  data is valid in the cycle after the request.
*/
interface memBusIf #(
  parameter int memAddrBits = 12
);
  import pdp8Pkg::*;

  logic req;
  logic we;
  logic [memAddrBits-1:0] addr;
  pdp8Word wdata;
  pdp8Word rdata;

  modport requester (
    output req, we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

// ==== hw/pdp8Pkg.sv ====
/*
  Machine types for the PDP-8 core. Bit numbers count from the LSB,
  so octal 0200 in an instruction is bit 7.
*/
package pdp8Pkg;

  typedef logic [11:0] pdp8Word;
  typedef logic [6:0] pdp8PageOffset;

  typedef enum logic [2:0] {
    opAnd, opTad, opIsz, opDca, opJms, opJmp, opIot, opOpr
  } pdp8Opcode;

  // Accumulator operation for the current cycle
  typedef enum logic [2:0] {
    accNone, accAnd, accTad, accClear, accOpr
  } accCmd;

  // Memory reference fields
  localparam int irIndBit  = 8;
  localparam int irPageBit = 7;

  // OPR group select and the CLA bit shared by both groups
  localparam int oprGroupBit  = 8;
  localparam int oprGroup3Bit = 0;
  localparam int oprCla       = 7;

  // Group 1 microcode bits
  localparam int oprCll   = 6;
  localparam int oprCma   = 5;
  localparam int oprCml   = 4;
  localparam int oprRar   = 3;
  localparam int oprRal   = 2;
  localparam int oprTwice = 1;
  localparam int oprIac   = 0;

  // Group 2 microcode bits
  localparam int oprSma      = 6;
  localparam int oprSza      = 5;
  localparam int oprSnl      = 4;
  localparam int oprRevSense = 3;
  localparam int oprHlt      = 1;

endpackage

// ==== hw/pdp8Top.sv ====
/*
  PDP-8 subsystem with an AXI4-Lite host port in place of the front panel.
  Memory size follows memAddrBits, PC stays 12 bits and wraps into it.
*/
module pdp8Top #(
  parameter int memAddrBits = 12
) (
  input  logic CLK,
  input  logic arstN,
  input  logic awvalid,
  output logic awready,
  input  hostPkg::hostAddr awaddr,
  input  logic wvalid,
  output logic wready,
  input  hostPkg::hostData wdata,
  input  logic [3:0] wstrb,
  output logic bvalid,
  input  logic bready,
  output hostPkg::axiResp bresp,
  input  logic arvalid,
  output logic arready,
  input  hostPkg::hostAddr araddr,
  output logic rvalid,
  input  logic rready,
  output hostPkg::hostData rdata,
  output hostPkg::axiResp rresp,
  output logic running
);
  import pdp8Pkg::*;

  pdp8Word pc, ir, operand, ac, startPc;
  accCmd cmd;
  logic link, skip;
  logic startPulse, stopPulse, startPcLoad;

  memBusIf #(.memAddrBits(memAddrBits)) cpuMem ();
  memBusIf #(.memAddrBits(memAddrBits)) hostMem ();

  axiLiteHost #(.memAddrBits(memAddrBits)) host0 (.mem(hostMem), .*);

  sequencer #(.memAddrBits(memAddrBits)) seq0 (.mem(cpuMem), .*);

  accumulatorUnit acc0 (.*);

  coreMemory #(.memAddrBits(memAddrBits)) core0 (
    .CLK      (CLK),
    .cpuPort  (cpuMem),
    .hostPort (hostMem)
  );

endmodule

// ==== hw/sequencer.sv ====
/*
  Instruction cycle control for the PDP-8 core. IOT and group 3 OPR run as
  no-ops, and auto-index locations behave as plain indirect words.
  Stop and HLT take effect at the end of the current instruction.
*/
module sequencer #(
  parameter int memAddrBits = 12
) (
  input  logic CLK,
  input  logic arstN,
  memBusIf.requester mem,
  input  logic startPulse,
  input  logic stopPulse,
  input  logic startPcLoad,
  input  pdp8Pkg::pdp8Word startPc,
  output logic running,
  output pdp8Pkg::pdp8Word pc,
  output pdp8Pkg::pdp8Word ir,
  output pdp8Pkg::pdp8Word operand,
  output pdp8Pkg::accCmd cmd,
  input  pdp8Pkg::pdp8Word ac,
  input  logic skip
);
  import pdp8Pkg::*;

  typedef enum logic [2:0] {
    fetch, irLoad, defer, deferLoad, exec, execLoad, writeBack
  } seqState;

  seqState state, nextState;
  pdp8Opcode opcode, loadOp;
  pdp8PageOffset offset;
  pdp8Word ea;
  pdp8Word iszData;
  logic stopReq;
  logic endInstr;
  logic haltHit;

  assign opcode  = pdp8Opcode'(ir[11:9]);
  assign loadOp  = pdp8Opcode'(mem.rdata[11:9]);
  assign offset  = mem.rdata[6:0];
  assign operand = mem.rdata;
  assign haltHit = (state == exec) && (opcode == opOpr) && ir[oprGroupBit]
                   && !ir[oprGroup3Bit] && ir[oprHlt];

  always_comb begin
    nextState = state;
    case (state)
      fetch:     if (running) nextState = irLoad;
      irLoad: begin
        // OPR and IOT have no address field to follow
        if (loadOp != opOpr && loadOp != opIot && mem.rdata[irIndBit])
          nextState = defer;
        else
          nextState = exec;
      end
      defer:     nextState = deferLoad;
      deferLoad: nextState = exec;
      exec: begin
        if (opcode == opAnd || opcode == opTad || opcode == opIsz)
          nextState = execLoad;
        else
          nextState = fetch;
      end
      execLoad:  nextState = (opcode == opIsz) ? writeBack : fetch;
      default:   nextState = fetch;
    endcase
  end

  assign endInstr = (state != fetch) && (nextState == fetch);

  // Memory requests and accumulator commands per state
  always_comb begin
    mem.req   = 1'b0;
    mem.we    = 1'b0;
    mem.addr  = ea[memAddrBits-1:0];
    mem.wdata = ac;
    cmd       = accNone;
    case (state)
      fetch: begin
        mem.req  = running;
        mem.addr = pc[memAddrBits-1:0];
      end
      defer: mem.req = 1'b1;
      exec: begin
        case (opcode)
          opAnd, opTad, opIsz: mem.req = 1'b1;
          opDca: begin
            mem.req = 1'b1;
            mem.we  = 1'b1;
            cmd     = accClear;
          end
          opJms: begin
            mem.req   = 1'b1;
            mem.we    = 1'b1;
            mem.wdata = pc;
          end
          opOpr:   cmd = accOpr;
          default: ;
        endcase
      end
      execLoad: begin
        if (opcode == opAnd) cmd = accAnd;
        if (opcode == opTad) cmd = accTad;
      end
      writeBack: begin
        mem.req   = 1'b1;
        mem.we    = 1'b1;
        mem.wdata = iszData;
      end
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (state == execLoad) iszData <= mem.rdata + 1'b1;
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state   <= fetch;
      running <= 1'b0;
      stopReq <= 1'b0;
      pc      <= '0;
      ir      <= '0;
      ea      <= '0;
    end else begin
      state <= nextState;
      case (state)
        irLoad: begin
          ir <= mem.rdata;
          pc <= pc + 1'b1;
          // Page of the instruction itself, before the increment lands
          ea <= {mem.rdata[irPageBit] ? pc[11:7] : 5'b0, offset};
        end
        deferLoad: ea <= mem.rdata;
        exec: begin
          if (opcode == opJmp) pc <= ea;
          if (opcode == opJms) pc <= ea + 1'b1;
          if (opcode == opOpr && skip) pc <= pc + 1'b1;
        end
        writeBack: if (iszData == '0) pc <= pc + 1'b1;
        default: ;
      endcase

      if (!running) begin
        if (startPcLoad) pc <= startPc;
        if (startPulse) running <= 1'b1;
        stopReq <= 1'b0;
      end else if (endInstr && (stopReq || stopPulse || haltHit)) begin
        running <= 1'b0;
        stopReq <= 1'b0;
      end else if (stopPulse) begin
        stopReq <= 1'b1;
      end
    end
  end

endmodule

// ==== src.f ====
hw/pdp8Pkg.sv
hw/hostPkg.sv
hw/memBusIf.sv
hw/sequencer.sv
hw/accumulatorUnit.sv
hw/coreMemory.sv
hw/axiLiteHost.sv
hw/pdp8Top.sv
tb/pdp8Tb.sv

// ==== tb/pdp8Tb.sv ====
/*
  Testbench for pdp8Top with the default 4K core. Inputs change 2 ns after
  the rising edge and outputs are sampled at the same point. Programs are
  encoded from the instruction formats and loaded over the AXI port.
*/
module pdp8Tb;
  timeunit 1ns;
  timeprecision 100ps;
  import pdp8Pkg::*;
  import hostPkg::*;

  localparam int axiTimeout = 40;
  localparam int haltPolls  = 200;

  // OPR microcoded words
  localparam pdp8Word insClaCll    = 12'o7300;
  localparam pdp8Word insHlt       = 12'o7402;
  localparam pdp8Word insRtl       = 12'o7006;
  localparam pdp8Word insClaCmaIac = 12'o7241;
  localparam pdp8Word insCml       = 12'o7020;
  localparam pdp8Word insSza       = 12'o7440;
  localparam pdp8Word insSna       = 12'o7450;
  localparam pdp8Word insSnl       = 12'o7420;

  logic CLK = 1'b0;
  logic arstN;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, running;
  hostAddr awaddr, araddr;
  hostData wdata, rdata;
  logic [3:0] wstrb;
  axiResp bresp, rresp;

  int checks = 0;
  int errors = 0;
  logic [31:0] rngState = 32'd24036;
  pdp8Word image[$];

  pdp8Top dut0 (.*);

  always #10 CLK = ~CLK;

  property heldUntilTaken(valid, ready);
    @(posedge CLK) disable iff (!arstN) valid && !ready |=> valid;
  endproperty

  assert property (heldUntilTaken(bvalid, bready)) else begin
    errors++;
    $display("bvalid dropped before bready accepted the response");
  end

  assert property (heldUntilTaken(rvalid, rready)) else begin
    errors++;
    $display("rvalid dropped before rready accepted the data");
  end

  assert property (@(posedge CLK) disable iff (!arstN) wready == awready) else begin
    errors++;
    $display("wready and awready did not rise together");
  end

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // Memory reference word with the page bit set for targets off page zero
  function automatic pdp8Word mri(pdp8Opcode op, logic ind, pdp8Word target);
    logic page;
    page = (target[11:7] != 5'd0);
    return {op, ind, page, target[6:0]};
  endfunction

  function automatic hostAddr winAddr(pdp8Word a);
    return memWindow + {2'b00, a, 2'b00};
  endfunction

  task automatic tick();
    @(posedge CLK);
    #2;
  endtask

  task automatic abortRun(input string why);
    errors++;
    $display("Timeout: %s", why);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic axiWrite(input hostAddr addr, input hostData data, output axiResp resp);
    int waitCnt;
    int delay;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waitCnt = 0;
    while (!awready) begin
      tick();
      waitCnt++;
      if (waitCnt > axiTimeout) abortRun("write address was never accepted");
    end
    tick();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waitCnt = 0;
    while (!bvalid) begin
      tick();
      waitCnt++;
      if (waitCnt > axiTimeout) abortRun("write response never arrived");
    end
    // Random back-pressure on the response
    delay = int'(nextRandom() % 3);
    repeat (delay) tick();
    resp   = bresp;
    bready = 1'b1;
    tick();
    bready = 1'b0;
  endtask

  task automatic axiRead(input hostAddr addr, output hostData data, output axiResp resp);
    int waitCnt;
    int delay;
    araddr  = addr;
    arvalid = 1'b1;
    waitCnt = 0;
    while (!arready) begin
      tick();
      waitCnt++;
      if (waitCnt > axiTimeout) abortRun("read address was never accepted");
    end
    tick();
    arvalid = 1'b0;
    waitCnt = 0;
    while (!rvalid) begin
      tick();
      waitCnt++;
      if (waitCnt > axiTimeout) abortRun("read data never arrived");
    end
    delay = int'(nextRandom() % 3);
    repeat (delay) tick();
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    tick();
    rready = 1'b0;
  endtask

  task automatic writeChecked(input hostAddr addr, input hostData data,
                              input axiResp expResp);
    axiResp resp;
    axiWrite(addr, data, resp);
    checkValue("bresp", resp, expResp);
  endtask

  task automatic readChecked(input hostAddr addr, input string name,
                             input hostData expData, input axiResp expResp);
    hostData data;
    axiResp resp;
    axiRead(addr, data, resp);
    checkValue("rresp", resp, expResp);
    if (expResp == respOkay) checkValue(name, data, expData);
  endtask

  task automatic loadImage(input pdp8Word base);
    for (int i = 0; i < image.size(); i++) begin
      writeChecked(winAddr(base + pdp8Word'(i)), hostData'(image[i]), respOkay);
    end
  endtask

  task automatic startAt(input pdp8Word startPc);
    writeChecked(regStartPc, hostData'(startPc), respOkay);
    writeChecked(regCtrl, 32'h1 << ctrlStartBit, respOkay);
  endtask

  task automatic waitHalt();
    hostData status;
    axiResp resp;
    int polls;
    polls  = 0;
    status = 32'h1;
    while (status[statusRunBit]) begin
      axiRead(regStatus, status, resp);
      polls++;
      if (polls > haltPolls) abortRun("CPU kept running past the poll limit");
    end
  endtask

  initial begin : stimulus
    hostData data;
    pdp8Word a, b, m, x, k, value, addr, r1;
    logic [12:0] sum;
    logic [12:0] model;
    pdp8Word mk1, mk2, mk3;
    int n;
    arstN   = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = '0;
    repeat (3) @(posedge CLK);
    #2;
    arstN = 1'b1;
    tick();

    // Reset state, memory window, unmapped offsets
    checkValue("running", running, 1'b0);
    readChecked(regStatus, "status", 0, respOkay);
    readChecked(regAc, "ac", 0, respOkay);
    readChecked(regPc, "pc", 0, respOkay);
    for (int i = 0; i < 20; i++) begin
      addr = pdp8Word'(nextRandom());
      data = nextRandom();
      writeChecked(winAddr(addr), data, respOkay);
      readChecked(winAddr(addr), "memory word", data & 32'h0000_0FFF, respOkay);
    end
    readChecked(16'h0014, "unmapped", 0, respSlvErr);
    writeChecked(16'h0100, 32'h1, respSlvErr);

    // TAD, TAD, AND, DCA on page 1
    a = pdp8Word'(nextRandom());
    b = pdp8Word'(nextRandom());
    m = pdp8Word'(nextRandom());
    image = '{insClaCll, mri(opTad, 0, 12'o0220), mri(opTad, 0, 12'o0221),
              mri(opAnd, 0, 12'o0222), mri(opDca, 0, 12'o0223), insHlt};
    loadImage(12'o0200);
    image = '{a, b, m, 12'o0000};
    loadImage(12'o0220);
    startAt(12'o0200);
    waitHalt();
    sum = {1'b0, a} + {1'b0, b};
    readChecked(winAddr(12'o0223), "stored word", {20'h0, sum[11:0] & m}, respOkay);
    readChecked(regAc, "ac and link", {19'h0, sum[12], 12'o0000}, respOkay);
    readChecked(regPc, "pc", 32'o0206, respOkay);

    // ISZ loop, then TAD I through a current page pointer
    n = 1 + int'(nextRandom() % 8);
    x = pdp8Word'(nextRandom());
    image = '{insClaCll, mri(opIsz, 0, 12'o0420), mri(opJmp, 0, 12'o0401),
              mri(opTad, 1, 12'o0421), insHlt};
    loadImage(12'o0400);
    image = '{pdp8Word'(-n), 12'o0430};
    loadImage(12'o0420);
    image = '{x};
    loadImage(12'o0430);
    startAt(12'o0400);
    waitHalt();
    readChecked(winAddr(12'o0420), "loop counter", 0, respOkay);
    readChecked(regAc, "ac and link", {20'h0, x}, respOkay);
    readChecked(regPc, "pc", 32'o0405, respOkay);

    // JMS with return through JMP I
    k = pdp8Word'(nextRandom());
    image = '{insClaCll, mri(opJms, 0, 12'o0610), insHlt};
    loadImage(12'o0600);
    image = '{12'o0000, mri(opTad, 0, 12'o0620), mri(opJmp, 1, 12'o0610)};
    loadImage(12'o0610);
    image = '{k};
    loadImage(12'o0620);
    startAt(12'o0600);
    waitHalt();
    readChecked(winAddr(12'o0610), "return address", 32'o0602, respOkay);
    readChecked(regPc, "pc", 32'o0603, respOkay);
    readChecked(regAc, "ac and link", {20'h0, k}, respOkay);

    // Operate group 1 and 2 with both Link outcomes for SNL
    for (int round = 0; round < 2; round++) begin
      x = pdp8Word'(nextRandom());
      x[10] = round[0];
      image = '{insClaCll, mri(opTad, 0, 12'o1040), insRtl, mri(opDca, 0, 12'o1041),
                insClaCmaIac, insSza, mri(opIsz, 0, 12'o1042), insCml, insSnl,
                mri(opIsz, 0, 12'o1043), insSna, mri(opIsz, 0, 12'o1044), insHlt};
      loadImage(12'o1000);
      image = '{x, 12'o0000, 12'o0000, 12'o0000, 12'o0000};
      loadImage(12'o1040);
      startAt(12'o1000);
      waitHalt();
      // Expected values stepped through on {link, ac}
      model = {1'b0, x};
      model = {model[11:0], model[12]};
      model = {model[11:0], model[12]};
      r1    = model[11:0];
      model = {model[12], 12'o7777} + 13'd1;
      mk1   = (model[11:0] == 12'o0000) ? 12'o0000 : 12'o0001;
      model[12] = ~model[12];
      mk2   = model[12] ? 12'o0000 : 12'o0001;
      mk3   = (model[11:0] != 12'o0000) ? 12'o0000 : 12'o0001;
      readChecked(winAddr(12'o1041), "rotated ac", {20'h0, r1}, respOkay);
      readChecked(winAddr(12'o1042), "sza marker", {20'h0, mk1}, respOkay);
      readChecked(winAddr(12'o1043), "snl marker", {20'h0, mk2}, respOkay);
      readChecked(winAddr(12'o1044), "sna marker", {20'h0, mk3}, respOkay);
      readChecked(regAc, "ac and link", {19'h0, model}, respOkay);
      readChecked(regPc, "pc", 32'o1015, respOkay);
    end

    // Host access while a JMP loop runs
    value = pdp8Word'(nextRandom());
    image = '{mri(opJmp, 0, 12'o1200)};
    loadImage(12'o1200);
    image = '{value};
    loadImage(12'o1300);
    startAt(12'o1200);
    readChecked(regStatus, "status", 1, respOkay);
    checkValue("running", running, 1'b1);
    writeChecked(winAddr(12'o1300), hostData'(~value), respSlvErr);
    readChecked(winAddr(12'o1300), "memory word", 0, respSlvErr);
    writeChecked(regStartPc, 32'o0200, respSlvErr);
    writeChecked(regCtrl, 32'h1 << ctrlStopBit, respOkay);
    waitHalt();
    checkValue("running", running, 1'b0);
    readChecked(winAddr(12'o1300), "guard word", {20'h0, value}, respOkay);
    readChecked(winAddr(12'o1200), "loop word", {20'h0, mri(opJmp, 0, 12'o1200)}, respOkay);
    readChecked(regPc, "pc", 32'o1200, respOkay);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
